// File: Makefile
VERILATOR := verilator
TOP       := cmdSeqTb
FILELIST  := filelist.f
OBJDIR    := obj_dir
FLAGS     := --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits nonzero on $$fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -o $(TOP) \
		-f $(FILELIST)
	./$(OBJDIR)/$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: cmdBusPort.sv
`default_nettype none

module cmdBusPort
(
    input  logic                 FCLK_IN,
    input  logic                 rst,
    input  logic [15:0]          busAddr,
    input  logic [7:0]           busWrData,
    input  logic                 rdB,
    input  logic                 wrB,
    output cmdSeqPkg::busWrite_t hostWrite,
    output logic [15:0]          readAddr
);

    import cmdSeqPkg::*;

    logic        wrBQ;
    logic        wrBQ2;
    logic        rdBQ;
    logic [15:0] addrQ;
    logic [7:0]  dataQ;
    logic [15:0] relAddr;
    logic        wrFall;
    logic        inWindow;
    logic        wrValid;
    logic [15:0] wrAddr;
    logic [7:0]  wrData;

    // Strobes idle high
    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
        begin
            wrBQ  <= 1'b1;
            wrBQ2 <= 1'b1;
            rdBQ  <= 1'b1;
        end
        else
        begin
            wrBQ  <= wrB;
            wrBQ2 <= wrBQ;
            rdBQ  <= rdB;
        end
    end

    always_ff @(posedge FCLK_IN)
    begin
        addrQ <= busAddr;
        dataQ <= busWrData;
    end

    assign relAddr  = addrQ - BusWindow;
    assign wrFall   = wrBQ2 & ~wrBQ;
    assign inWindow = (addrQ >= BusWindow) && (relAddr < RegMemEnd);

    ////////////////////
    // Write decode

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            wrValid <= 1'b0;
        else
            wrValid <= wrFall & inWindow;
    end

    always_ff @(posedge FCLK_IN)
    begin
        wrAddr <= relAddr;
        wrData <= dataQ;
    end

    assign hostWrite = '{valid: wrValid, addr: wrAddr, data: wrData};

    // Frozen once the read strobe is seen low
    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            readAddr <= '0;
        else if (rdBQ)
            readAddr <= busAddr - BusWindow;
    end

endmodule

`default_nettype wire

// File: cmdPatternMem.sv
`default_nettype none

module cmdPatternMem
(
    input  logic                           FCLK_IN,
    input  cmdSeqPkg::busWrite_t           hostWrite,
    input  logic [cmdSeqPkg::MemAddrW-1:0] hostRdAddr,
    output logic [7:0]                     hostRdData,
    input  logic [cmdSeqPkg::MemAddrW-1:0] seqRdAddr,
    output logic [7:0]                     seqRdData
);

    import cmdSeqPkg::*;

    logic [7:0]          mem [MemBytes];
    logic                memWr;
    logic [MemAddrW-1:0] wrIdx;
    logic [MemAddrW-1:0] hostIdx;

    assign memWr = hostWrite.valid && (hostWrite.addr >= RegMemBase)
                   && (hostWrite.addr < RegMemEnd);

    // Host offsets start at RegMemBase, wrapping modulo the depth
    assign wrIdx   = hostWrite.addr[MemAddrW-1:0] - RegMemBase[MemAddrW-1:0];
    assign hostIdx = hostRdAddr - RegMemBase[MemAddrW-1:0];

    always_ff @(posedge FCLK_IN)
    begin
        if (memWr)
            mem[wrIdx] <= hostWrite.data;
        hostRdData <= mem[hostIdx];
        seqRdData  <= mem[seqRdAddr];
    end

endmodule

`default_nettype wire

// File: cmdPatternReader.sv
`default_nettype none

module cmdPatternReader
(
    input  logic                           FCLK_IN,
    input  logic                           rst,
    input  logic                           seqStart,
    input  cmdSeqPkg::sizeBits_t           patternSize,
    input  logic [7:0]                     repeatCount,
    output logic [cmdSeqPkg::MemAddrW-1:0] seqRdAddr,
    input  logic [7:0]                     seqRdData,
    input  logic                           creditReturn,
    output logic                           chunkValid,
    output cmdSeqPkg::cmdChunk_t           chunk
);

    import cmdSeqPkg::*;

    typedef logic [$clog2(CreditMax+1)-1:0] credit_t;

    logic                active;
    sizeBits_t           sizeQ;
    sizeBits_t           bitsLeft;
    logic [7:0]          repLeft;
    logic [MemAddrW-1:0] byteAddr;
    credit_t             credits;
    logic                issue;
    logic                repEnd;
    logic [3:0]          issueBits;
    logic [3:0]          chunkBits;
    logic                chunkLast;

    assign issue     = active && (credits != '0);
    assign repEnd    = (bitsLeft <= 16'd8);
    assign issueBits = repEnd ? bitsLeft[3:0] : 4'd8;
    assign seqRdAddr = byteAddr;

    ////////////////////
    // Pattern walk

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
        begin
            active   <= 1'b0;
            sizeQ    <= '0;
            bitsLeft <= '0;
            repLeft  <= '0;
            byteAddr <= '0;
        end
        else if (seqStart)
        begin
            active   <= 1'b1;
            sizeQ    <= patternSize;
            bitsLeft <= patternSize;
            repLeft  <= repeatCount;
            byteAddr <= '0;
        end
        else if (issue)
        begin
            if (repEnd)
            begin
                // Next repetition starts over at byte 0
                byteAddr <= '0;
                bitsLeft <= sizeQ;
                if (repLeft == 8'd0)
                    active <= 1'b0;
                else
                    repLeft <= repLeft - 8'd1;
            end
            else
            begin
                byteAddr <= byteAddr + 1'b1;
                bitsLeft <= bitsLeft - 16'd8;
            end
        end
    end

    // One credit per read, one back per consumed chunk
    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            credits <= credit_t'(CreditMax);
        else
        begin
            case ({issue, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////
    // Chunk output

    // Tags trail the read by the memory latency
    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            chunkValid <= 1'b0;
        else
            chunkValid <= issue;
    end

    always_ff @(posedge FCLK_IN)
    begin
        chunkBits <= issueBits;
        chunkLast <= repEnd && (repLeft == 8'd0);
    end

    assign chunk = '{data: seqRdData, bitCount: chunkBits, last: chunkLast};

endmodule

`default_nettype wire

// File: cmdRegs.sv
`default_nettype none

module cmdRegs
(
    input  logic                 FCLK_IN,
    input  logic                 rst,
    input  cmdSeqPkg::busWrite_t hostWrite,
    input  logic [15:0]          readAddr,
    input  logic [7:0]           memRdData,
    input  logic                 seqDone,
    output logic                 seqStart,
    output cmdSeqPkg::sizeBits_t patternSize,
    output logic [7:0]           repeatCount,
    output logic [7:0]           busRdData
);

    import cmdSeqPkg::*;

    logic       busy;
    logic       startWr;
    logic [7:0] rdMux;

    // Any data value on the start register
    assign startWr = hostWrite.valid && (hostWrite.addr == RegStart);

    // Only from idle, and only with something to send
    assign seqStart = startWr && !busy && (patternSize != '0);

    ////////////////////
    // Config registers

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
        begin
            patternSize <= '0;
            repeatCount <= '0;
        end
        else if (hostWrite.valid)
        begin
            case (hostWrite.addr)
                RegSizeLo: patternSize[7:0]  <= hostWrite.data;
                RegSizeHi: patternSize[15:8] <= hostWrite.data;
                RegRepeat: repeatCount       <= hostWrite.data;
                default:   ;
            endcase
        end
    end

    // Busy from accepted start until the serializer drains
    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            busy <= 1'b0;
        else if (seqStart)
            busy <= 1'b1;
        else if (seqDone)
            busy <= 1'b0;
    end

    ////////////////////
    // Read-back

    always_comb
    begin
        rdMux = 8'h00;
        if ((readAddr >= RegMemBase) && (readAddr < RegMemEnd))
            rdMux = memRdData;
        else
        begin
            case (readAddr)
                RegStatus: rdMux = {7'b0, busy};
                RegSizeLo: rdMux = patternSize[7:0];
                RegSizeHi: rdMux = patternSize[15:8];
                RegRepeat: rdMux = repeatCount;
                // Start register and unused offsets read as zero
                default:   rdMux = 8'h00;
            endcase
        end
    end

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
            busRdData <= 8'h00;
        else
            busRdData <= rdMux;
    end

endmodule

`default_nettype wire

// File: cmdSeqPkg.sv
`default_nettype none

package cmdSeqPkg;

    ////////////////////
    // Register map

    // Host window base
    localparam logic [15:0] BusWindow  = 16'h4000;

    // Offsets inside the window
    localparam logic [15:0] RegStatus  = 16'd0;
    localparam logic [15:0] RegStart   = 16'd1;
    localparam logic [15:0] RegSizeLo  = 16'd3;
    localparam logic [15:0] RegSizeHi  = 16'd4;
    localparam logic [15:0] RegRepeat  = 16'd5;
    localparam logic [15:0] RegMemBase = 16'd8;

    ////////////////////
    // Sizes

    localparam int MemBytes  = 128;
    localparam int MemAddrW  = 7;
    localparam int CreditMax = 2;

    // First offset past the pattern memory
    localparam logic [15:0] RegMemEnd = RegMemBase + 16'(MemBytes);

    ////////////////////
    // Shared types

    // Pattern length in bits
    typedef logic [15:0] sizeBits_t;

    // One decoded host write
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic [7:0]  data;
    } busWrite_t;

    // One pattern byte, shifted out MSB first
    typedef struct packed {
        logic [7:0] data;
        logic [3:0] bitCount;
        logic       last;
    } cmdChunk_t;

endpackage

`default_nettype wire

// File: cmdSeqTbTasks.svh
`ifndef CMD_SEQ_TB_TASKS_SVH
`define CMD_SEQ_TB_TASKS_SVH

////////////////////
// Bus access

// Every task starts and ends 1 ns after a rising edge
task automatic nextCycle();
    @(posedge FCLK_IN);
    #1;
endtask

task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
    busAddr   = addr;
    busWrData = data;
    nextCycle();
    wrB = 1'b0;
    repeat (3)
        nextCycle();
    wrB = 1'b1;
    nextCycle();
endtask

task automatic busRead(input logic [15:0] addr, output logic [7:0] data);
    busAddr = addr;
    nextCycle();
    rdB = 1'b0;
    repeat (4)
        nextCycle();
    // Sampled while the strobe is still low
    data = busRdData;
    rdB  = 1'b1;
    nextCycle();
endtask

task automatic regWrite(input logic [15:0] rel, input logic [7:0] data);
    busWrite(BusWindow + rel, data);
endtask

task automatic regRead(input logic [15:0] rel, output logic [7:0] data);
    busRead(BusWindow + rel, data);
endtask

task automatic setLength(input logic [15:0] bits, input logic [7:0] repeats);
    regWrite(RegSizeLo, bits[7:0]);
    regWrite(RegSizeHi, bits[15:8]);
    regWrite(RegRepeat, repeats);
endtask

// Keeps a copy of every byte sent to the pattern memory
task automatic writePattern(input int idx, input logic [7:0] data);
    regWrite(RegMemBase + 16'(idx), data);
    patternModel[idx] = data;
endtask

////////////////////
// Random data

function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    if (state[0])
        return (state >> 1) ^ LfsrPoly;
    return state >> 1;
endfunction

task automatic randomByte(output logic [7:0] value);
    value = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
        value     = {value[6:0], lfsrState[0]};
        lfsrState = lfsrStep(lfsrState);
    end
endtask

////////////////////
// Checking

task automatic checkValue(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected)
    begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        abortRun();
    end
endtask

// Collects cmdData until cmdValid falls and watches for a late restart
task automatic captureBits();
    int waited;
    capturedBits.delete();
    waited = 0;
    while (!cmdValid)
    begin
        if (waited == StartWait)
        begin
            $display("cmdValid never rose within %0d cycles of the start", StartWait);
            abortRun();
        end
        nextCycle();
        waited++;
    end
    while (cmdValid)
    begin
        capturedBits.push_back(cmdData);
        nextCycle();
    end
    repeat (GapWatch)
    begin
        nextCycle();
        if (cmdValid)
        begin
            $display("cmdValid dropped and rose again in the middle of the stream");
            abortRun();
        end
    end
endtask

task automatic startAndCapture();
    fork
        regWrite(RegStart, 8'h01);
        captureBits();
    join
endtask

`endif

// File: cmdSeqTb.sv
`default_nettype none

module cmdSeqTb;

    timeunit 1ns;
    timeprecision 1ps;

    import cmdSeqPkg::*;

    localparam int          ResetCycles = 16;
    localparam logic [4:0]  TriggerCode = 5'b11101;
    localparam logic [15:0] LfsrPoly    = 16'hB400;
    localparam logic [15:0] LfsrSeed    = 16'h0003;
    localparam int          StartWait   = 30;
    localparam int          GapWatch    = 8;
    localparam int          SilentWait  = 50;

    // Twice the worst-case stream bits of all tests plus bus traffic
    localparam int TotalBits      = 5 + 69 + 640 + 1378 + SilentWait;
    localparam int BusOps         = 160;
    localparam int BusOpCycles    = 6;
    localparam int WatchdogCycles = 2 * (TotalBits + BusOps * BusOpCycles
                                         + 6 * (StartWait + GapWatch) + ResetCycles);

    logic        FCLK_IN;
    logic        rst;
    logic [15:0] busAddr;
    logic [7:0]  busWrData;
    logic        rdB;
    logic        wrB;
    logic [7:0]  busRdData;
    logic        cmdData;
    logic        cmdValid;

    logic [15:0] lfsrState;
    logic [7:0]  patternModel [MemBytes];
    logic        capturedBits [$];

    `include "cmdSeqTbTasks.svh"

    cmdSeqTop cmdSeqTop_i (
        .FCLK_IN   (FCLK_IN),
        .rst       (rst),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .rdB       (rdB),
        .wrB       (wrB),
        .busRdData (busRdData),
        .cmdData   (cmdData),
        .cmdValid  (cmdValid)
    );

    always #10 FCLK_IN = ~FCLK_IN;

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Pattern bits in memory order and MSB first, restarting each repetition
    task automatic checkStream(input int size, input int repeats);
        int idx;
        checkValue("captured bit count", capturedBits.size(), size * (repeats + 1));
        foreach (capturedBits[i])
        begin
            idx = i % size;
            checkValue($sformatf("cmdData bit %0d", i), capturedBits[i],
                       patternModel[idx / 8][7 - (idx % 8)]);
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic registerAccess();
        logic [7:0] value;
        logic [7:0] memData [4];
        int         memIdx [4];
        memIdx = '{0, 1, 5, 127};
        setLength(16'h1234, 8'h07);
        foreach (memIdx[i])
        begin
            randomByte(memData[i]);
            writePattern(memIdx[i], memData[i]);
        end
        // Writes below the window that alias size and memory offsets
        busWrite(16'h0003, 8'hFF);
        busWrite(16'h0008, ~memData[0]);
        busWrite(BusWindow - 16'd1, 8'hFF);
        regRead(RegSizeLo, value);
        checkValue("sizeLo", value, 8'h34);
        regRead(RegSizeHi, value);
        checkValue("sizeHi", value, 8'h12);
        regRead(RegRepeat, value);
        checkValue("repeat", value, 8'h07);
        foreach (memIdx[i])
        begin
            regRead(RegMemBase + 16'(memIdx[i]), value);
            checkValue($sformatf("mem[%0d]", memIdx[i]), value, memData[i]);
        end
        regRead(RegStatus, value);
        checkValue("status", value, 8'h00);
    endtask

    task automatic triggerPattern();
        writePattern(0, {TriggerCode, 3'b000});
        setLength(16'd5, 8'd0);
        startAndCapture();
        checkValue("captured bit count", capturedBits.size(), 5);
        for (int i = 0; i < 5; i++)
            checkValue($sformatf("cmdData bit %0d", i), capturedBits[i], TriggerCode[4 - i]);
    endtask

    task automatic threeBytePattern();
        writePattern(0, 8'hB6);
        writePattern(1, 8'h1D);
        writePattern(2, 8'h7E);
        setLength(16'd23, 8'd2);
        startAndCapture();
        checkStream(23, 2);
    endtask

    task automatic busyDuringRun();
        logic [7:0] value;
        for (int i = 0; i < 16; i++)
        begin
            randomByte(value);
            writePattern(i, value);
        end
        setLength(16'd128, 8'd4);
        fork
            captureBits();
            begin
                regWrite(RegStart, 8'h01);
                while (!cmdValid)
                    nextCycle();
                regRead(RegStatus, value);
                checkValue("status while running", value, 8'h01);
                // Must not restart or stretch the stream
                regWrite(RegStart, 8'h01);
            end
        join
        checkStream(128, 4);
        regRead(RegStatus, value);
        checkValue("status after run", value, 8'h00);
    endtask

    task automatic randomPattern();
        logic [7:0] value;
        for (int i = 0; i < 87; i++)
        begin
            randomByte(value);
            writePattern(i, value);
        end
        setLength(16'd689, 8'd1);
        startAndCapture();
        checkStream(689, 1);
    endtask

    task automatic zeroSize();
        logic [7:0] value;
        setLength(16'd0, 8'd0);
        fork
            regWrite(RegStart, 8'h01);
            repeat (SilentWait)
            begin
                nextCycle();
                if (cmdValid)
                begin
                    $display("cmdValid rose after a start with size 0");
                    abortRun();
                end
            end
        join
        regRead(RegStatus, value);
        checkValue("status with size 0", value, 8'h00);
    endtask

    ////////////////////
    // Sequence

    initial
    begin
        FCLK_IN    = 1'b0;
        rst        = 1'b1;
        busAddr    = 16'h0000;
        busWrData  = 8'h00;
        rdB        = 1'b1;
        wrB        = 1'b1;
        lfsrState  = LfsrSeed;
        repeat (ResetCycles)
            @(posedge FCLK_IN);
        #1;
        rst = 1'b0;
        nextCycle();

        registerAccess();
        triggerPattern();
        threeBytePattern();
        busyDuringRun();
        randomPattern();
        zeroSize();

        $display("Test completed successfully");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WatchdogCycles)
            @(posedge FCLK_IN);
        $display("Watchdog expired after %0d cycles", WatchdogCycles);
        abortRun();
    end

endmodule

`default_nettype wire

// File: cmdSeqTop.sv
`default_nettype none

module cmdSeqTop
(
    input  logic        FCLK_IN,
    input  logic        rst,
    input  logic [15:0] busAddr,
    input  logic [7:0]  busWrData,
    input  logic        rdB,
    input  logic        wrB,
    output logic [7:0]  busRdData,
    output logic        cmdData,
    output logic        cmdValid
);

    import cmdSeqPkg::*;

    busWrite_t           hostWrite;
    logic [15:0]         readAddr;
    logic [7:0]          memRdData;
    logic                seqStart;
    logic                seqDone;
    sizeBits_t           patternSize;
    logic [7:0]          repeatCount;
    logic [MemAddrW-1:0] seqRdAddr;
    logic [7:0]          seqRdData;
    logic                creditReturn;
    logic                chunkValid;
    cmdChunk_t           chunk;

    ////////////////////
    // Host side

    cmdBusPort cmdBusPort_i (
        .FCLK_IN   (FCLK_IN),
        .rst       (rst),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .rdB       (rdB),
        .wrB       (wrB),
        .hostWrite (hostWrite),
        .readAddr  (readAddr)
    );

    cmdRegs cmdRegs_i (
        .FCLK_IN     (FCLK_IN),
        .rst         (rst),
        .hostWrite   (hostWrite),
        .readAddr    (readAddr),
        .memRdData   (memRdData),
        .seqDone     (seqDone),
        .seqStart    (seqStart),
        .patternSize (patternSize),
        .repeatCount (repeatCount),
        .busRdData   (busRdData)
    );

    // Memory takes the low bits of the window offset
    cmdPatternMem cmdPatternMem_i (
        .FCLK_IN    (FCLK_IN),
        .hostWrite  (hostWrite),
        .hostRdAddr (readAddr[MemAddrW-1:0]),
        .hostRdData (memRdData),
        .seqRdAddr  (seqRdAddr),
        .seqRdData  (seqRdData)
    );

    ////////////////////
    // Sequencer path

    cmdPatternReader cmdPatternReader_i (
        .FCLK_IN      (FCLK_IN),
        .rst          (rst),
        .seqStart     (seqStart),
        .patternSize  (patternSize),
        .repeatCount  (repeatCount),
        .seqRdAddr    (seqRdAddr),
        .seqRdData    (seqRdData),
        .creditReturn (creditReturn),
        .chunkValid   (chunkValid),
        .chunk        (chunk)
    );

    cmdSerializer cmdSerializer_i (
        .FCLK_IN      (FCLK_IN),
        .rst          (rst),
        .chunkValid   (chunkValid),
        .chunk        (chunk),
        .creditReturn (creditReturn),
        .seqDone      (seqDone),
        .cmdData      (cmdData),
        .cmdValid     (cmdValid)
    );

endmodule

`default_nettype wire

// File: cmdSerializer.sv
`default_nettype none

module cmdSerializer
(
    input  logic                 FCLK_IN,
    input  logic                 rst,
    input  logic                 chunkValid,
    input  cmdSeqPkg::cmdChunk_t chunk,
    output logic                 creditReturn,
    output logic                 seqDone,
    output logic                 cmdData,
    output logic                 cmdValid
);

    import cmdSeqPkg::*;

    typedef logic [$clog2(CreditMax)-1:0]   qPtr_t;
    typedef logic [$clog2(CreditMax+1)-1:0] qCount_t;

    cmdChunk_t  queue [CreditMax];
    qPtr_t      wrPtr;
    qPtr_t      rdPtr;
    qCount_t    count;
    cmdChunk_t  head;
    logic       pop;
    logic       finalBit;
    logic [7:0] shiftReg;
    logic [3:0] bitCnt;
    logic       shiftLast;

    assign head     = queue[rdPtr];
    assign finalBit = cmdValid && (bitCnt == 4'd1);
    // Reload on the final bit so repetitions join without a gap
    assign pop      = (count != '0) && (!cmdValid || finalBit);
    assign cmdData  = cmdValid & shiftReg[7];

    ////////////////////
    // Chunk queue

    always_ff @(posedge FCLK_IN)
    begin
        if (chunkValid)
            queue[wrPtr] <= chunk;
    end

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (chunkValid)
                wrPtr <= (wrPtr == qPtr_t'(CreditMax - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == qPtr_t'(CreditMax - 1)) ? '0 : rdPtr + 1'b1;
            case ({chunkValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Shifter

    always_ff @(posedge FCLK_IN)
    begin
        if (rst)
        begin
            cmdValid     <= 1'b0;
            bitCnt       <= '0;
            shiftLast    <= 1'b0;
            creditReturn <= 1'b0;
            seqDone      <= 1'b0;
        end
        else
        begin
            creditReturn <= pop;
            seqDone      <= finalBit && shiftLast;
            if (pop)
            begin
                cmdValid  <= 1'b1;
                bitCnt    <= head.bitCount;
                shiftLast <= head.last;
            end
            else if (finalBit)
                cmdValid <= 1'b0;
            else if (cmdValid)
                bitCnt <= bitCnt - 4'd1;
        end
    end

    // MSB leaves first
    always_ff @(posedge FCLK_IN)
    begin
        if (pop)
            shiftReg <= head.data;
        else
            shiftReg <= {shiftReg[6:0], 1'b0};
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
cmdSeqPkg.sv
cmdBusPort.sv
cmdRegs.sv
cmdPatternMem.sv
cmdPatternReader.sv
cmdSerializer.sv
cmdSeqTop.sv
cmdSeqTb.sv
